/* all.f */
+incdir+common
common/servo_pkg.sv
rtl/servo_cmd_rx.sv
rtl/servo_width_bank.sv
servo_channel/servo_frame_timer.sv
servo_channel/servo_channel_fsm.sv
servo_channel/servo_on_timer.sv
rtl/servo_ctrl_top.sv
test/servo_tb.sv

/* common/servo_macros.svh */
// Widths and limits are in ticks; defaults are scaled far below real 20 ms timing for simulation

`ifndef SERVO_MACROS_SVH
`define SERVO_MACROS_SVH

// Number of servo outputs
`define SERVO_NUM_CHANNELS 4

// Channel index width, must cover SERVO_NUM_CHANNELS
`define SERVO_CHAN_BITS 2

// Clock cycles per width tick
`define SERVO_TICK_DIV 4

// Servo period in ticks
`define SERVO_PERIOD_TICKS 60

// Period in clock cycles, used by the frame counter
`define SERVO_PERIOD_CYCLES (`SERVO_PERIOD_TICKS * `SERVO_TICK_DIV)

// Width value size
`define SERVO_WIDTH_BITS 8

// Pulse width limits in ticks
// Both must stay below the period and fit in SERVO_WIDTH_BITS
`define SERVO_MIN_WIDTH 10
`define SERVO_MAX_WIDTH 40

`endif

/* common/servo_pkg.sv */
// Enum encodings are fixed; the opcode values are also what the host drives on cmd_op

package servo_pkg;

    // Host command opcodes
    typedef enum logic [1:0] {
        OP_SET_WIDTH = 2'd0,
        OP_ENABLE    = 2'd1,
        OP_DISABLE   = 2'd2,
        OP_NOP       = 2'd3
    } servo_op_t;

    // Per-channel pulse sequencer states
    typedef enum logic [2:0] {
        CH_HOLD        = 3'd0,   // enable hold
        CH_WAIT_PERIOD = 3'd1,   // wait for period start
        CH_LOAD        = 3'd2,   // load ON timer
        CH_PULSE_ON    = 3'd3,   // pulse high until ON time done
        CH_PULSE_OFF   = 3'd4    // pulse low, back to hold
    } servo_ch_state_t;

    // Command receiver handshake states
    typedef enum logic {
        RX_IDLE = 1'b0,
        RX_ACK  = 1'b1
    } servo_rx_state_t;

endpackage

/* rtl/servo_cmd_rx.sv */
// Host must hold op, chan and data stable while req is high; the write strobe is combinational

`include "servo_macros.svh"

module servo_cmd_rx
    import servo_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_req,
    input  servo_op_t                     cmd_op,
    input  logic [`SERVO_CHAN_BITS-1:0]   cmd_chan,
    input  logic [`SERVO_WIDTH_BITS-1:0]  cmd_data,
    output logic                          cmd_ack,
    output logic                          wr_en,
    output servo_op_t                     wr_op,
    output logic [`SERVO_CHAN_BITS-1:0]   wr_chan,
    output logic [`SERVO_WIDTH_BITS-1:0]  wr_data
);

    servo_rx_state_t state, next_state;

    // Handshake state register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= RX_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Accept in idle, then hold ack until the host drops req
    always_comb begin
        next_state = state;
        unique case (state)
            RX_IDLE: next_state = cmd_req ? RX_ACK : RX_IDLE;
            RX_ACK:  next_state = cmd_req ? RX_ACK : RX_IDLE;
            default: next_state = RX_IDLE;
        endcase
    end

    // New request seen in idle
    // NOP still walks through the ack phase but never writes the bank
    assign wr_en   = (state == RX_IDLE) && cmd_req && (cmd_op != OP_NOP);

    // Fields are sampled by the bank in the strobe cycle
    assign wr_op   = cmd_op;
    assign wr_chan = cmd_chan;
    assign wr_data = cmd_data;

    // Moore ack
    assign cmd_ack = (state == RX_ACK);

    // Ack only rises after req was seen high
    assert property (@(posedge clk) disable iff (!reset)
        $rose(cmd_ack) |-> $past(cmd_req));

    // One strobe per request, taken in idle and followed by ack
    assert property (@(posedge clk) disable iff (!reset)
        wr_en |-> (state == RX_IDLE) ##1 (cmd_ack && !wr_en));

endmodule

/* rtl/servo_ctrl_top.sv */
// Pulses start 2 cycles after each period start; all channels share one frame

`include "servo_macros.svh"

module servo_ctrl_top
    import servo_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cmd_req,
    input  servo_op_t                       cmd_op,
    input  logic [`SERVO_CHAN_BITS-1:0]     cmd_chan,
    input  logic [`SERVO_WIDTH_BITS-1:0]    cmd_data,
    output logic                            cmd_ack,
    output logic [`SERVO_NUM_CHANNELS-1:0]  servo_pulse
);

    // Receiver to bank
    logic                                    wr_en;
    servo_op_t                               wr_op;
    logic [`SERVO_CHAN_BITS-1:0]             wr_chan;
    logic [`SERVO_WIDTH_BITS-1:0]            wr_data;

    // Frame strobe, shared
    logic                                    period_start;

    // Bank to channels
    logic [`SERVO_NUM_CHANNELS-1:0]          enable;
    logic [`SERVO_NUM_CHANNELS-1:0][`SERVO_WIDTH_BITS-1:0] active_width;

    // FSM and ON timer pairs
    logic [`SERVO_NUM_CHANNELS-1:0]          timer_load;
    logic [`SERVO_NUM_CHANNELS-1:0]          on_done;

    servo_cmd_rx servo_cmd_rx_i (
        .clk, .reset,
        .cmd_req, .cmd_op, .cmd_chan, .cmd_data, .cmd_ack,
        .wr_en, .wr_op, .wr_chan, .wr_data
    );

    servo_width_bank servo_width_bank_i (
        .clk, .reset,
        .wr_en, .wr_op, .wr_chan, .wr_data,
        .period_start, .enable, .active_width
    );

    servo_frame_timer servo_frame_timer_i (
        .clk, .reset, .period_start
    );

    // One sequencer and ON timer per output
    for (genvar ch = 0; ch < `SERVO_NUM_CHANNELS; ch++) begin : g_channel
        servo_channel_fsm servo_channel_fsm_i (
            .clk, .reset,
            .enable       (enable[ch]),
            .period_start (period_start),
            .on_done      (on_done[ch]),
            .servo_pulse  (servo_pulse[ch]),
            .timer_load   (timer_load[ch])
        );

        servo_on_timer servo_on_timer_i (
            .clk, .reset,
            .load    (timer_load[ch]),
            .width   (active_width[ch]),
            .on_done (on_done[ch])
        );
    end

endmodule

/* rtl/servo_width_bank.sv */
// New widths only go live on period_start; out-of-range widths are clamped silently

`include "servo_macros.svh"

module servo_width_bank
    import servo_pkg::*;
(
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic                                               wr_en,
    input  servo_op_t                                          wr_op,
    input  logic [`SERVO_CHAN_BITS-1:0]                        wr_chan,
    input  logic [`SERVO_WIDTH_BITS-1:0]                       wr_data,
    input  logic                                               period_start,
    output logic [`SERVO_NUM_CHANNELS-1:0]                     enable,
    output logic [`SERVO_NUM_CHANNELS-1:0][`SERVO_WIDTH_BITS-1:0] active_width
);

    localparam logic [`SERVO_WIDTH_BITS-1:0] MIN_W = `SERVO_WIDTH_BITS'(`SERVO_MIN_WIDTH);
    localparam logic [`SERVO_WIDTH_BITS-1:0] MAX_W = `SERVO_WIDTH_BITS'(`SERVO_MAX_WIDTH);

    // Widths written by the host, waiting for the next period
    logic [`SERVO_NUM_CHANNELS-1:0][`SERVO_WIDTH_BITS-1:0] pending_width;

    // Limit a requested width to the servo range
    function automatic logic [`SERVO_WIDTH_BITS-1:0] clamp_width(
        input logic [`SERVO_WIDTH_BITS-1:0] w
    );
        if (w < MIN_W) return MIN_W;
        if (w > MAX_W) return MAX_W;
        return w;
    endfunction

    // Host writes to the enable flags and pending widths
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            enable <= '0;
            for (int i = 0; i < `SERVO_NUM_CHANNELS; i++) begin
                pending_width[i] <= MIN_W;
            end
        end else if (wr_en) begin
            unique case (wr_op)
                OP_SET_WIDTH: pending_width[wr_chan] <= clamp_width(wr_data);
                OP_ENABLE:    enable[wr_chan] <= 1'b1;
                OP_DISABLE:   enable[wr_chan] <= 1'b0;
                default:      ;
            endcase
        end
    end

    // All channels switch widths together at the period boundary
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `SERVO_NUM_CHANNELS; i++) begin
                active_width[i] <= MIN_W;
            end
        end else if (period_start) begin
            active_width <= pending_width;
        end
    end

    // Active widths never leave the clamp range
    for (genvar ch = 0; ch < `SERVO_NUM_CHANNELS; ch++) begin : g_width_check
        assert property (@(posedge clk) disable iff (!reset)
            active_width[ch] >= MIN_W && active_width[ch] <= MAX_W);
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the servo controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module servo_tb -o servo_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/servo_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$SIM_LOG"; then
    exit 0
fi
exit 1

/* servo_channel/servo_channel_fsm.sv */
// Period start is only seen in CH_WAIT_PERIOD; a disable takes effect after the running pulse

module servo_channel_fsm
    import servo_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic period_start,
    input  logic on_done,
    output logic servo_pulse,
    output logic timer_load
);

    servo_ch_state_t state, next_state;

    // State register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= CH_HOLD;
        end else begin
            state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        unique case (state)
            // Parked until the host enables the channel
            CH_HOLD:
                next_state = enable ? CH_WAIT_PERIOD : CH_HOLD;
            // Line up with the shared frame
            CH_WAIT_PERIOD:
                next_state = period_start ? CH_LOAD : CH_WAIT_PERIOD;
            // Single cycle where the timer picks up the new active width
            CH_LOAD:
                next_state = CH_PULSE_ON;
            // Pulse runs to completion even if enable drops
            CH_PULSE_ON:
                next_state = on_done ? CH_PULSE_OFF : CH_PULSE_ON;
            CH_PULSE_OFF:
                next_state = CH_HOLD;
            default:
                next_state = CH_HOLD;
        endcase
    end

    // Moore outputs decoded from state only
    assign timer_load  = (state == CH_LOAD);
    assign servo_pulse = (state == CH_PULSE_ON);

    // Load and pulse are exclusive
    assert property (@(posedge clk) disable iff (!reset)
        !(servo_pulse && timer_load));

endmodule

/* servo_channel/servo_frame_timer.sv */
// Free-running from reset; the period is fixed at build time by SERVO_PERIOD_CYCLES

`include "servo_macros.svh"

module servo_frame_timer (
    input  logic clk,
    input  logic reset,
    output logic period_start
);

    localparam int CNT_BITS = $clog2(`SERVO_PERIOD_CYCLES);
    localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(`SERVO_PERIOD_CYCLES - 1);

    // Clock count within the current period
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (count == LAST) begin
            // Wrap to the start of the next period
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // One cycle at the end of every period
    // First strobe lands a full period after reset
    assign period_start = (count == LAST);

endmodule

/* servo_channel/servo_on_timer.sv */
// on_done is valid only while counting; width 0 loads an idle timer and never flags done

`include "servo_macros.svh"

module servo_on_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load,
    input  logic [`SERVO_WIDTH_BITS-1:0]  width,
    output logic                          on_done
);

    localparam int PRE_BITS = (`SERVO_TICK_DIV > 1) ? $clog2(`SERVO_TICK_DIV) : 1;
    localparam logic [PRE_BITS-1:0] PRE_LAST = PRE_BITS'(`SERVO_TICK_DIV - 1);

    // Clock count inside the current tick
    logic [PRE_BITS-1:0]          prescale;
    // Ticks still to run
    logic [`SERVO_WIDTH_BITS-1:0] ticks_left;
    logic                         tick_end;

    assign tick_end = (prescale == PRE_LAST);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prescale   <= '0;
            ticks_left <= '0;
        end else if (load) begin
            // Restart tick phase with the new width
            prescale   <= '0;
            ticks_left <= width;
        end else if (ticks_left != '0) begin
            prescale <= tick_end ? '0 : prescale + 1'b1;
            if (tick_end) begin
                ticks_left <= ticks_left - 1'b1;
            end
        end
    end

    // Last clock of the last tick
    // Gives width x TICK_DIV cycles of pulse after the load cycle
    assign on_done = (ticks_left == `SERVO_WIDTH_BITS'(1)) && tick_end;

endmodule

/* test/servo_tb.sv */
// Relies on all channels sharing one frame; widths are modeled from host writes only
`include "servo_macros.svh"

module servo_tb
    import servo_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NCH          = `SERVO_NUM_CHANNELS;
    localparam int CHAN_W       = `SERVO_CHAN_BITS;
    localparam int TICK         = `SERVO_TICK_DIV;
    localparam int PERIOD       = `SERVO_PERIOD_TICKS * `SERVO_TICK_DIV;
    localparam int MIN_W        = `SERVO_MIN_WIDTH;
    localparam int MAX_W        = `SERVO_MAX_WIDTH;
    localparam int HS_TIMEOUT   = 16;
    localparam int RISE_TIMEOUT = 2 * PERIOD + 16;

    logic                          clk;
    logic                          reset;
    logic                          cmd_req;
    servo_op_t                     cmd_op;
    logic [CHAN_W-1:0]             cmd_chan;
    logic [`SERVO_WIDTH_BITS-1:0]  cmd_data;
    logic                          cmd_ack;
    logic [NCH-1:0]                servo_pulse;
    logic [NCH-1:0]                measured;

    // Count of rising edges since time zero
    int cyc = 0;

    // Host side model of the latest write, the one before it and its send cycle
    int pend [NCH]      = '{default: `SERVO_MIN_WIDTH};
    int prev_pend [NCH] = '{default: `SERVO_MIN_WIDTH};
    int pend_cyc [NCH]  = '{default: -1000};
    bit off_req [NCH]   = '{default: 1'b0};

    servo_ctrl_top servo_ctrl_top_i (
        .clk, .reset,
        .cmd_req, .cmd_op, .cmd_chan, .cmd_data,
        .cmd_ack, .servo_pulse
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Servo range limits applied to a host width
    function automatic int limit_width(input int w);
        return (w < MIN_W) ? MIN_W : ((w > MAX_W) ? MAX_W : w);
    endfunction

    // Full four-phase exchange that starts and ends on a falling edge
    task automatic send_cmd(input servo_op_t op, input logic [CHAN_W-1:0] ch, input int data);
        int waited;
        cmd_op   = op;
        cmd_chan = ch;
        cmd_data = `SERVO_WIDTH_BITS'(data);
        cmd_req  = 1'b1;
        // Bank strobe lands on the next rising edge
        case (op)
            OP_SET_WIDTH: begin
                prev_pend[ch] = pend[ch];
                pend[ch]      = limit_width(data);
                pend_cyc[ch]  = cyc;
            end
            OP_ENABLE:  off_req[ch] = 1'b0;
            OP_DISABLE: off_req[ch] = 1'b1;
            default:    ;
        endcase
        waited = 0;
        while (!cmd_ack && waited < HS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmd_ack) abort_run("ack never rose after a request");
        cmd_req = 1'b0;
        waited  = 0;
        while (cmd_ack && waited < HS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (cmd_ack) abort_run("ack never fell after req was dropped");
    endtask

    // Returns on the falling edge where the pulse is first seen high
    task automatic wait_rise(input logic [CHAN_W-1:0] ch);
        int  waited;
        bit  last;
        bit  rose;
        waited = 0;
        last   = servo_pulse[ch];
        rose   = 1'b0;
        while (!rose && waited < RISE_TIMEOUT) begin
            @(negedge clk);
            waited++;
            rose = servo_pulse[ch] && !last;
            last = servo_pulse[ch];
        end
        if (!rose) abort_run($sformatf("servo_pulse[%0d] never rose in time", ch));
    endtask

    // Outputs idle while reset is held
    assert property (@(posedge clk) !reset |-> (!cmd_ack && servo_pulse == '0))
        else abort_run($sformatf("ERR cmd_ack/servo_pulse got 0x%0h/0x%0h expected 0x0/0x0 in reset",
                                 $sampled(cmd_ack), $sampled(servo_pulse)));

    // Handshake ordering
    assert property (@(posedge clk) disable iff (!reset) $rose(cmd_req) |=> cmd_ack)
        else abort_run($sformatf("ERR cmd_ack got 0x%0h expected 0x1 after req rose",
                                 $sampled(cmd_ack)));
    assert property (@(posedge clk) disable iff (!reset) $fell(cmd_req) |=> !cmd_ack)
        else abort_run($sformatf("ERR cmd_ack got 0x%0h expected 0x0 after req fell",
                                 $sampled(cmd_ack)));
    assert property (@(posedge clk) disable iff (!reset) $rose(cmd_ack) |-> $past(cmd_req))
        else abort_run($sformatf("ERR cmd_req got 0x%0h expected 0x1 before ack rose",
                                 $past(cmd_req)));

    // One pulse monitor per output
    for (genvar g = 0; g < NCH; g++) begin : g_mon
        bit was_high  = 1'b0;
        bit seen      = 1'b0;
        bit broken    = 1'b0;
        bit quiet     = 1'b0;
        bit len_valid = 1'b0;
        bit gap_valid = 1'b0;
        bit gap_cont  = 1'b0;
        int rise_cyc  = 0;
        int exp_len   = 0;
        int got_len   = 0;
        int got_gap   = 0;
        int len_count = 0;

        assign measured[g] = (len_count >= 2);

        always @(negedge clk) begin
            len_valid = 1'b0;
            gap_valid = 1'b0;
            if (reset) begin
                if (servo_pulse[g] && !was_high) begin
                    // Frame start was two cycles back so later writes are not live yet
                    if (pend_cyc[g] < cyc - 2) begin
                        exp_len = pend[g] * TICK;
                    end else begin
                        exp_len = prev_pend[g] * TICK;
                    end
                    if (seen) begin
                        gap_valid = 1'b1;
                        got_gap   = cyc - rise_cyc;
                        gap_cont  = !broken;
                    end
                    seen     = 1'b1;
                    broken   = 1'b0;
                    rise_cyc = cyc;
                end
                if (!servo_pulse[g] && was_high) begin
                    got_len   = cyc - rise_cyc;
                    len_valid = 1'b1;
                    len_count++;
                    // Last pulse after a disable has ended
                    if (off_req[g]) quiet = 1'b1;
                end
                if (off_req[g]) begin
                    broken = 1'b1;
                end else begin
                    quiet = 1'b0;
                end
                was_high = servo_pulse[g];
            end
        end

        assert property (@(posedge clk) disable iff (!reset) len_valid |-> got_len == exp_len)
            else abort_run($sformatf("ERR servo_pulse[%0d] high cycles got 0x%0h expected 0x%0h",
                                     g, got_len, exp_len));
        assert property (@(posedge clk) disable iff (!reset)
            (gap_valid && gap_cont) |-> got_gap == PERIOD)
            else abort_run($sformatf("ERR servo_pulse[%0d] rise spacing got 0x%0h expected 0x%0h",
                                     g, got_gap, PERIOD));
        // Gap across a disable still lands on the frame grid
        assert property (@(posedge clk) disable iff (!reset)
            (gap_valid && !gap_cont) |-> (got_gap % PERIOD) == 0)
            else abort_run($sformatf("ERR servo_pulse[%0d] rise spacing 0x%0h off frame 0x%0h",
                                     g, got_gap, PERIOD));
        assert property (@(posedge clk) disable iff (!reset) quiet |-> !servo_pulse[g])
            else abort_run($sformatf("ERR servo_pulse[%0d] got 0x%0h expected 0x0 while disabled",
                                     g, $sampled(servo_pulse[g])));
    end

    initial begin
        void'($urandom(35));
        cmd_req  = 1'b0;
        cmd_op   = OP_NOP;
        cmd_chan = '0;
        cmd_data = '0;
        reset    = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        // Start-up widths with channel 1 below and channel 2 above the limits
        send_cmd(OP_SET_WIDTH, 2'd0, int'($urandom_range(MAX_W, MIN_W)));
        send_cmd(OP_SET_WIDTH, 2'd1, 3);
        send_cmd(OP_SET_WIDTH, 2'd2, 200);
        send_cmd(OP_SET_WIDTH, 2'd3, int'($urandom_range(MAX_W, MIN_W)));
        for (int i = 0; i < NCH; i++) begin
            send_cmd(OP_ENABLE, CHAN_W'(i), 0);
        end
        wait_rise(2'd0);
        wait_rise(2'd0);

        // Write while channel 0 is mid-pulse
        send_cmd(OP_SET_WIDTH, 2'd0, int'($urandom_range(MAX_W, MIN_W)));
        wait_rise(2'd0);
        wait_rise(2'd0);

        // NOP on the max-width channel leaves its pulse length alone
        send_cmd(OP_NOP, 2'd2, 0);
        wait_rise(2'd2);
        wait_rise(2'd2);

        // Disable channel 3 during its pulse and keep it off for several frames
        wait_rise(2'd3);
        send_cmd(OP_DISABLE, 2'd3, 0);
        wait_rise(2'd0);
        wait_rise(2'd0);
        wait_rise(2'd0);
        send_cmd(OP_SET_WIDTH, 2'd3, int'($urandom_range(255, 0)));
        send_cmd(OP_ENABLE, 2'd3, 0);
        wait_rise(2'd3);
        wait_rise(2'd3);

        // Random writes at random frame offsets that may land near a frame start
        repeat (8) begin
            repeat (int'($urandom_range(PERIOD - 1, 0))) @(negedge clk);
            send_cmd(OP_SET_WIDTH, CHAN_W'($urandom_range(NCH - 1, 0)),
                     int'($urandom_range(255, 0)));
        end
        for (int i = 0; i < NCH; i++) begin
            wait_rise(CHAN_W'(i));
            wait_rise(CHAN_W'(i));
        end

        if (measured != {NCH{1'b1}}) begin
            abort_run("a channel produced fewer than two measured pulses");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
